/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --timescale 1ns/1ps
TOP       := lsu_mem_tb
RTL_TOP   := lsu_mem_top
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --binary --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Done: no errors$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(VFLAGS) --lint-only --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/lsu_mem_checks.svh */
`ifndef LSU_MEM_CHECKS_SVH
`define LSU_MEM_CHECKS_SVH

// flags that wait_high can poll
localparam int sel_rreq_ready = 0;
localparam int sel_rres_valid = 1;
localparam int sel_wreq_ready = 2;
localparam int sel_wres_valid = 3;
// cycles before a wait gives up
localparam int wait_limit     = 50;

// data word against the expected value
task automatic check_word(input string name, input lsu_pkg::word_t got,
                          input lsu_pkg::word_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[FAIL] %t %s got %h expected %h", $time, name, got, exp);
  end
endtask

// single handshake flag
task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[FAIL] %t %s got %b expected %b", $time, name, got, exp);
  end
endtask

function automatic logic flag(input int sel);
  case (sel)
    sel_rreq_ready: return rreq_ready;
    sel_rres_valid: return rres_valid;
    sel_wreq_ready: return wreq_ready;
    default:        return wres_valid;
  endcase
endfunction

// poll once per clock until the flag is high
task automatic wait_high(input int sel, input string name);
  int n;
  n = 0;
  while (flag(sel) !== 1'b1) begin
    tick();
    n++;
    if (n > wait_limit) begin
      errors++;
      $display("timeout: %s stayed low for %0d cycles, at %t", name, n, $time);
      end_run();
    end
  end
endtask

// one store through the write lane
// hold > 0 keeps wres_ready low for that many cycles
task automatic do_store(input lsu_pkg::word_t addr, input lsu_pkg::st_func_t func,
                        input lsu_pkg::word_t data, input int hold);
  int i;
  waddr      = addr;
  wfunc      = func;
  wdata      = data;
  wreq_valid = 1'b1;
  wres_ready = (hold == 0);
  wait_high(sel_wreq_ready, "wreq_ready");
  check_bit("wres_valid", wres_valid, 1'b0);
  tick();
  wreq_valid = 1'b0;
  // response due one clock after the request handshake
  check_bit("wres_valid", wres_valid, 1'b1);
  wait_high(sel_wres_valid, "wres_valid");
  for (i = 0; i < hold; i++) begin
    check_bit("wres_valid", wres_valid, 1'b1);
    check_bit("wreq_ready", wreq_ready, 1'b0);
    tick();
  end
  wres_ready = 1'b1;
  tick();
  model_write(addr, func, data);
endtask

// one load through the read lane, data is the returned word
task automatic do_load(input lsu_pkg::word_t addr, input lsu_pkg::ld_func_t func,
                       input int hold, output lsu_pkg::word_t data);
  int i;
  raddr      = addr;
  rfunc      = func;
  rreq_valid = 1'b1;
  rres_ready = (hold == 0);
  wait_high(sel_rreq_ready, "rreq_ready");
  check_bit("rres_valid", rres_valid, 1'b0);
  tick();
  rreq_valid = 1'b0;
  check_bit("rres_valid", rres_valid, 1'b1);
  wait_high(sel_rres_valid, "rres_valid");
  data = rdata;
  // stalled response must not move
  for (i = 0; i < hold; i++) begin
    check_bit("rres_valid", rres_valid, 1'b1);
    check_bit("rreq_ready", rreq_ready, 1'b0);
    check_word("rdata", rdata, data);
    tick();
  end
  rres_ready = 1'b1;
  tick();
endtask

`endif

/* bench/lsu_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_tb;

  logic              clk;
  logic              rstn;
  // load lane
  lsu_pkg::word_t    raddr;
  lsu_pkg::ld_func_t rfunc;
  logic              rreq_valid;
  logic              rreq_ready;
  lsu_pkg::word_t    rdata;
  logic              rres_valid;
  logic              rres_ready;
  // store lane
  lsu_pkg::word_t    waddr;
  lsu_pkg::st_func_t wfunc;
  lsu_pkg::word_t    wdata;
  logic              wreq_valid;
  logic              wreq_ready;
  logic              wres_valid;
  logic              wres_ready;

  // byte image of the ram, wraps like the beat index
  logic [7:0] model [bus_pkg::mem_words * 8];
  int         errors;
  int         checks;
  int         tests;
  int         seed;
  lsu_pkg::ld_func_t ld_list [5] = '{lsu_pkg::ld_bs, lsu_pkg::ld_hs, lsu_pkg::ld_w,
                                     lsu_pkg::ld_bu, lsu_pkg::ld_hu};

  // port names match the testbench signals
  lsu_mem_top lsu_mem_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  `include "lsu_mem_checks.svh"

  // next drive point, just after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // fill value, depends on every address bit
  function automatic lsu_pkg::word_t fill(input lsu_pkg::word_t a);
    return (a * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  // only the addressed one, two or four bytes change
  function automatic void model_write(input lsu_pkg::word_t addr,
                                      input lsu_pkg::st_func_t func,
                                      input lsu_pkg::word_t data);
    int base;
    int n;
    int i;
    base = int'(addr % (bus_pkg::mem_words * 8));
    n    = (func == lsu_pkg::st_b) ? 1 : (func == lsu_pkg::st_h) ? 2 : 4;
    for (i = 0; i < n; i++) begin
      model[base + i] = data[8*i +: 8];
    end
  endfunction

  // expected load result, little-endian bytes then extension
  function automatic lsu_pkg::word_t predict(input lsu_pkg::word_t addr,
                                             input lsu_pkg::ld_func_t func);
    int b;
    b = int'(addr % (bus_pkg::mem_words * 8));
    case (func)
      lsu_pkg::ld_bs: return {{24{model[b][7]}}, model[b]};
      lsu_pkg::ld_bu: return {24'h0, model[b]};
      lsu_pkg::ld_hs: return {{16{model[b+1][7]}}, model[b+1], model[b]};
      lsu_pkg::ld_hu: return {16'h0, model[b+1], model[b]};
      default:        return {model[b+3], model[b+2], model[b+1], model[b]};
    endcase
  endfunction

  task automatic load_check(input lsu_pkg::word_t addr, input lsu_pkg::ld_func_t func,
                            input int hold);
    lsu_pkg::word_t got;
    do_load(addr, func, hold, got);
    check_word("rdata", got, predict(addr, func));
  endtask

  task automatic report_test(input string name, input int start);
    tests++;
    $display("test %s finished with %0d mismatches", name, errors - start);
  endtask

  task automatic end_run();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // words over the low 256 bytes plus far addresses, both beat halves
  task automatic test_word_roundtrip();
    lsu_pkg::word_t far [4] = '{32'h0000_07f8, 32'h0000_07fc, 32'h1234_5560, 32'h8000_0444};
    lsu_pkg::word_t a;
    int start;
    int i;
    start = errors;
    for (a = 0; a < 256; a += 4) begin
      do_store(a, lsu_pkg::st_w, fill(a), 0);
    end
    for (i = 0; i < 4; i++) begin
      do_store(far[i], lsu_pkg::st_w, fill(far[i]), 0);
    end
    for (a = 0; a < 256; a += 4) begin
      load_check(a, lsu_pkg::ld_w, 0);
    end
    for (i = 0; i < 4; i++) begin
      load_check(far[i], lsu_pkg::ld_w, 0);
    end
    report_test("word_roundtrip", start);
  endtask

  // narrow stores carry junk in the unused bytes of wdata
  task automatic test_narrow_stores();
    int start;
    int off;
    start = errors;
    for (off = 0; off < 8; off++) begin
      do_store(32'h40 + off, lsu_pkg::st_b, fill(32'h140 + off), 0);
      load_check(32'h40, lsu_pkg::ld_w, 0);
      load_check(32'h44, lsu_pkg::ld_w, 0);
    end
    for (off = 0; off < 8; off += 2) begin
      do_store(32'h48 + off, lsu_pkg::st_h, fill(32'h248 + off), 0);
      load_check(32'h48, lsu_pkg::ld_w, 0);
      load_check(32'h4c, lsu_pkg::ld_w, 0);
    end
    report_test("narrow_stores", start);
  endtask

  // bytes 01 7f ff 80 00 80 ff 7f, top bit clear and set
  task automatic test_load_extend();
    lsu_pkg::word_t got;
    int start;
    int off;
    start = errors;
    do_store(32'h80, lsu_pkg::st_w, 32'h80ff_7f01, 0);
    do_store(32'h84, lsu_pkg::st_w, 32'h7fff_8000, 0);
    for (off = 0; off < 8; off++) begin
      load_check(32'h80 + off, lsu_pkg::ld_bs, 0);
      load_check(32'h80 + off, lsu_pkg::ld_bu, 0);
      if (off % 2 == 0) begin
        load_check(32'h80 + off, lsu_pkg::ld_hs, 0);
        load_check(32'h80 + off, lsu_pkg::ld_hu, 0);
      end
    end
    // spot values straight from the extension rule
    do_load(32'h83, lsu_pkg::ld_bs, 0, got);
    check_word("rdata", got, 32'hffff_ff80);
    do_load(32'h83, lsu_pkg::ld_bu, 0, got);
    check_word("rdata", got, 32'h0000_0080);
    do_load(32'h81, lsu_pkg::ld_bs, 0, got);
    check_word("rdata", got, 32'h0000_007f);
    do_load(32'h82, lsu_pkg::ld_hs, 0, got);
    check_word("rdata", got, 32'hffff_80ff);
    do_load(32'h86, lsu_pkg::ld_hu, 0, got);
    check_word("rdata", got, 32'h0000_7fff);
    report_test("load_extend", start);
  endtask

  // exact one-clock latency is checked inside do_store and do_load
  task automatic test_latency();
    int start;
    start = errors;
    do_store(32'hc0, lsu_pkg::st_w, fill(32'hc0), 0);
    load_check(32'hc0, lsu_pkg::ld_w, 0);
    report_test("latency", start);
  endtask

  task automatic test_backpressure();
    int start;
    start = errors;
    do_store(32'hc4, lsu_pkg::st_h, fill(32'hc4), 5);
    load_check(32'hc4, lsu_pkg::ld_hu, 5);
    // both lanes after release
    do_store(32'hc7, lsu_pkg::st_b, fill(32'hc7), 0);
    load_check(32'hc4, lsu_pkg::ld_w, 0);
    report_test("backpressure", start);
  endtask

  // random mix inside the filled 256 bytes, upper bits wrap onto them
  task automatic test_random_mix();
    logic [31:0]       r;
    lsu_pkg::word_t    a;
    lsu_pkg::st_func_t sf;
    lsu_pkg::ld_func_t lf;
    int start;
    int i;
    start = errors;
    for (i = 0; i < 200; i++) begin
      r = $random(seed);
      a = $random(seed);
      a = a & 32'hffff_f8ff;
      if (r[0]) begin
        sf   = (r[2:1] == 2'd0) ? lsu_pkg::st_b : (r[2:1] == 2'd1) ? lsu_pkg::st_h : lsu_pkg::st_w;
        a[0] = a[0] & (sf == lsu_pkg::st_b);
        a[1] = a[1] & (sf != lsu_pkg::st_w);
        do_store(a, sf, $random(seed), 0);
      end else begin
        lf   = ld_list[int'(r[5:3]) % 5];
        a[0] = a[0] & (lf == lsu_pkg::ld_bs || lf == lsu_pkg::ld_bu);
        a[1] = a[1] & (lf != lsu_pkg::ld_w);
        load_check(a, lf, 0);
      end
    end
    report_test("random_mix", start);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    errors     = 0;
    checks     = 0;
    tests      = 0;
    seed       = 84;
    rstn       = 1'b0;
    raddr      = '0;
    rfunc      = lsu_pkg::ld_w;
    rreq_valid = 1'b0;
    rres_ready = 1'b1;
    waddr      = '0;
    wfunc      = lsu_pkg::st_w;
    wdata      = '0;
    wreq_valid = 1'b0;
    wres_ready = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rstn = 1'b1;
    test_word_roundtrip();
    test_narrow_stores();
    test_load_extend();
    test_latency();
    test_backpressure();
    test_random_mix();
    end_run();
  end

endmodule

`default_nettype wire

/* verilog/axi_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_sram (
  input  wire                 clk,
  input  wire                 rstn,
  // read address
  input  bus_pkg::bus_addr_t  araddr,
  input  wire                 arvalid,
  output logic                arready,
  // read data
  output bus_pkg::beat_t      rdata_beat,
  output logic                rvalid,
  input  wire                 rready,
  // write address
  input  bus_pkg::bus_addr_t  awaddr,
  input  bus_pkg::size_t      awsize,
  input  wire                 awvalid,
  output logic                awready,
  // write data
  input  bus_pkg::beat_t      wdata_beat,
  input  bus_pkg::strb_t      wstrb,
  input  wire                 wvalid,
  output logic                wready,
  // write response
  output logic                bvalid,
  input  wire                 bready
);

  // beat storage, contents undefined after reset
  bus_pkg::beat_t mem [bus_pkg::mem_words];

  logic                ar_hs;
  logic                r_hs;
  bus_pkg::mem_index_t rd_idx;

  logic                aw_hs;
  logic                w_hs;
  logic                aw_full;
  logic                w_full;
  bus_pkg::mem_index_t aw_idx_q;
  bus_pkg::beat_t      wdata_q;
  bus_pkg::strb_t      wstrb_q;
  logic                do_write;
  bus_pkg::mem_index_t wr_idx;
  bus_pkg::beat_t      wr_data;
  bus_pkg::strb_t      wr_strb;

  // read side
  assign ar_hs  = arvalid & arready;
  assign r_hs   = rvalid & rready;
  // beat index, upper address bits wrap
  assign rd_idx = araddr[bus_pkg::mem_index_bits+2:bus_pkg::off_bits];

  // one read in flight, arready back after the data handshake
  always_ff @(posedge clk) begin
    if (!rstn) begin
      arready <= 1'b1;
      rvalid  <= 1'b0;
    end else if (ar_hs) begin
      arready <= 1'b0;
      rvalid  <= 1'b1;
    end else if (r_hs) begin
      arready <= 1'b1;
      rvalid  <= 1'b0;
    end
  end

  // beat held until rready
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata_beat <= mem[rd_idx];
    end
  end

  // write side
  // awsize not needed, strobe already selects the lanes
  assign awready = ~aw_full & ~bvalid;
  assign wready  = ~w_full & ~bvalid;
  assign aw_hs   = awvalid & awready;
  assign w_hs    = wvalid & wready;

  // both halves present, either latched or arriving now
  assign do_write = (aw_full | aw_hs) & (w_full | w_hs);
  assign wr_idx   = aw_full ? aw_idx_q : awaddr[bus_pkg::mem_index_bits+2:bus_pkg::off_bits];
  assign wr_data  = w_full ? wdata_q : wdata_beat;
  assign wr_strb  = w_full ? wstrb_q : wstrb;

  // channel flags and response
  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      bvalid  <= 1'b0;
    end else if (do_write) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      bvalid  <= 1'b1;
    end else begin
      // park whichever half came first
      if (aw_hs) begin
        aw_full <= 1'b1;
      end
      if (w_hs) begin
        w_full <= 1'b1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // parked payload
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_idx_q <= awaddr[bus_pkg::mem_index_bits+2:bus_pkg::off_bits];
    end
    if (w_hs) begin
      wdata_q <= wdata_beat;
      wstrb_q <= wstrb;
    end
  end

  // strobed byte write
  always_ff @(posedge clk) begin
    if (do_write) begin
      for (int i = 0; i < bus_pkg::strb_bits; i++) begin
        if (wr_strb[i]) begin
          mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/bus_pkg.sv */
`default_nettype none

// 64-bit memory bus between the lsu stages and the ram
package bus_pkg;

  localparam int beat_bits      = 64;
  localparam int strb_bits      = beat_bits / 8;
  localparam int off_bits       = 3;
  localparam int mem_words      = 256;
  localparam int mem_index_bits = 8;

  typedef logic [beat_bits-1:0]      beat_t;
  typedef logic [strb_bits-1:0]      strb_t;
  typedef logic [31:0]               bus_addr_t;
  typedef logic [off_bits-1:0]       beat_off_t;
  typedef logic [2:0]                size_t;
  typedef logic [mem_index_bits-1:0] mem_index_t;

  // transfer size codes, log2 of byte count
  localparam size_t size_1 = 3'd0;
  localparam size_t size_2 = 3'd1;
  localparam size_t size_4 = 3'd2;

endpackage

`default_nettype wire

/* verilog/lsu_load_extract.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_extract (
  input  wire                 clk,
  input  wire                 rstn,
  // core load request
  input  lsu_pkg::word_t      raddr,
  input  lsu_pkg::ld_func_t   rfunc,
  input  wire                 rreq_valid,
  output logic                rreq_ready,
  // core load response
  output lsu_pkg::word_t      rdata,
  output logic                rres_valid,
  input  wire                 rres_ready,
  // bus read address
  output bus_pkg::bus_addr_t  araddr,
  output logic                arvalid,
  input  wire                 arready,
  // bus read data
  input  bus_pkg::beat_t      rdata_beat,
  input  wire                 rvalid,
  output logic                rready
);

  bus_pkg::beat_off_t off_q;
  lsu_pkg::ld_func_t  func_q;
  bus_pkg::beat_t     shifted;

  // request goes to the bus unchanged
  assign araddr     = raddr;
  assign arvalid    = rreq_valid;
  assign rreq_ready = arready;

  // offset and function kept until the beat comes back
  always_ff @(posedge clk) begin
    if (!rstn) begin
      off_q  <= '0;
      func_q <= lsu_pkg::ld_w;
    end else if (rreq_valid && rreq_ready) begin
      off_q  <= raddr[bus_pkg::off_bits-1:0];
      func_q <= rfunc;
    end
  end

  // addressed byte down to lane 0
  assign shifted = rdata_beat >> {off_q, 3'b000};

  // extend byte or halfword, word passes
  always_comb begin
    case (func_q)
      lsu_pkg::ld_bs: rdata = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::ld_bu: rdata = {24'b0, shifted[7:0]};
      lsu_pkg::ld_hs: rdata = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::ld_hu: rdata = {16'b0, shifted[15:0]};
      default:        rdata = shifted[31:0];
    endcase
  end

  // response handshake maps onto the read data channel
  assign rres_valid = rvalid;
  assign rready     = rres_ready;

endmodule

`default_nettype wire

/* verilog/lsu_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_top (
  input  wire                clk,
  input  wire                rstn,
  // load request and response
  input  lsu_pkg::word_t     raddr,
  input  lsu_pkg::ld_func_t  rfunc,
  input  wire                rreq_valid,
  output logic               rreq_ready,
  output lsu_pkg::word_t     rdata,
  output logic               rres_valid,
  input  wire                rres_ready,
  // store request and response
  input  lsu_pkg::word_t     waddr,
  input  lsu_pkg::st_func_t  wfunc,
  input  lsu_pkg::word_t     wdata,
  input  wire                wreq_valid,
  output logic               wreq_ready,
  output logic               wres_valid,
  input  wire                wres_ready
);

  // read bus
  bus_pkg::bus_addr_t araddr;
  logic               arvalid;
  logic               arready;
  bus_pkg::beat_t     rdata_beat;
  logic               rvalid;
  logic               rready;

  // write bus
  bus_pkg::bus_addr_t awaddr;
  bus_pkg::size_t     awsize;
  logic               awvalid;
  logic               awready;
  bus_pkg::beat_t     wdata_beat;
  bus_pkg::strb_t     wstrb;
  logic               wvalid;
  logic               wready;
  logic               bvalid;
  logic               bready;

  // store lane
  lsu_store_align lsu_store_align_inst (
    .clk        (clk),
    .rstn       (rstn),
    .waddr      (waddr),
    .wfunc      (wfunc),
    .wdata      (wdata),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready),
    .awaddr     (awaddr),
    .awsize     (awsize),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata_beat (wdata_beat),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready)
  );

  // load lane
  lsu_load_extract lsu_load_extract_inst (
    .clk        (clk),
    .rstn       (rstn),
    .raddr      (raddr),
    .rfunc      (rfunc),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .rdata      (rdata),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata_beat (rdata_beat),
    .rvalid     (rvalid),
    .rready     (rready)
  );

  // shared memory
  axi_sram axi_sram_inst (
    .clk        (clk),
    .rstn       (rstn),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata_beat (rdata_beat),
    .rvalid     (rvalid),
    .rready     (rready),
    .awaddr     (awaddr),
    .awsize     (awsize),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata_beat (wdata_beat),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready)
  );

endmodule

`default_nettype wire

/* verilog/lsu_pkg.sv */
`default_nettype none

// core-side view of the load/store unit
package lsu_pkg;

  // core word width and bytes per word
  localparam int word_bits  = 32;
  localparam int word_bytes = word_bits / 8;

  // data word or byte address as seen by the core
  typedef logic [word_bits-1:0] word_t;

  // load function, values match the RISC-V funct3 field
  typedef enum logic [2:0] {
    ld_bs = 3'b000,
    ld_hs = 3'b001,
    ld_w  = 3'b010,
    ld_bu = 3'b100,
    ld_hu = 3'b101
  } ld_func_t;

  // store function, also funct3
  typedef enum logic [2:0] {
    st_b = 3'b000,
    st_h = 3'b001,
    st_w = 3'b010
  } st_func_t;

  // byte-enable patterns before shifting by the offset
  localparam logic [7:0] mask_b = 8'b0000_0001;
  localparam logic [7:0] mask_h = 8'b0000_0011;
  localparam logic [7:0] mask_w = 8'b0000_1111;

endpackage

`default_nettype wire

/* verilog/lsu_store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
  input  wire                 clk,
  input  wire                 rstn,
  // core store request
  input  lsu_pkg::word_t      waddr,
  input  lsu_pkg::st_func_t   wfunc,
  input  lsu_pkg::word_t      wdata,
  input  wire                 wreq_valid,
  output logic                wreq_ready,
  // core store response
  output logic                wres_valid,
  input  wire                 wres_ready,
  // bus write address
  output bus_pkg::bus_addr_t  awaddr,
  output bus_pkg::size_t      awsize,
  output logic                awvalid,
  input  wire                 awready,
  // bus write data
  output bus_pkg::beat_t      wdata_beat,
  output bus_pkg::strb_t      wstrb,
  output logic                wvalid,
  input  wire                 wready,
  // bus write response
  input  wire                 bvalid,
  output logic                bready
);

  bus_pkg::beat_off_t off;
  bus_pkg::strb_t     mask;
  logic               aw_pend;
  logic               w_pend;

  // byte position inside the beat
  assign off = waddr[bus_pkg::off_bits-1:0];

  // width mask and size code from the function
  always_comb begin
    case (wfunc)
      lsu_pkg::st_b: begin
        mask   = lsu_pkg::mask_b;
        awsize = bus_pkg::size_1;
      end
      lsu_pkg::st_h: begin
        mask   = lsu_pkg::mask_h;
        awsize = bus_pkg::size_2;
      end
      default: begin
        mask   = lsu_pkg::mask_w;
        awsize = bus_pkg::size_4;
      end
    endcase
  end

  // move word and mask up to the addressed lanes
  assign wdata_beat = bus_pkg::beat_t'(wdata) << {off, 3'b000};
  assign wstrb      = mask << off;
  // beat-aligned address
  assign awaddr     = {waddr[31:bus_pkg::off_bits], {bus_pkg::off_bits{1'b0}}};

  // each channel offered until its own handshake
  assign awvalid = wreq_valid & aw_pend;
  assign wvalid  = wreq_valid & w_pend;

  // accept only when the last open channel completes
  assign wreq_ready = (aw_pend | w_pend) & (awready | ~aw_pend) & (wready | ~w_pend);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else if (bvalid && bready) begin
      // response done, rearm both channels
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else begin
      if (awvalid && awready) begin
        aw_pend <= 1'b0;
      end
      if (wvalid && wready) begin
        w_pend <= 1'b0;
      end
    end
  end

  // response goes straight to the core
  assign wres_valid = bvalid;
  assign bready     = wres_ready;

endmodule

`default_nettype wire

/* vlog.f */
+incdir+bench
verilog/lsu_pkg.sv
verilog/bus_pkg.sv
verilog/lsu_store_align.sv
verilog/lsu_load_extract.sv
verilog/axi_sram.sv
verilog/lsu_mem_top.sv
bench/lsu_mem_tb.sv
